//--- verilog/cpuPkg.sv
`default_nettype none

package cpuPkg;

    localparam int dataWidth = 32;
    localparam int regAddrWidth = 5;
    localparam int imemDepth = 64;
    localparam int dmemDepth = 64;
    localparam int imemAddrWidth = 6;

    // Function field codes of the R-type instructions.
    localparam logic [5:0] functAdd = 6'h20;
    localparam logic [5:0] functSub = 6'h22;
    localparam logic [5:0] functAnd = 6'h24;
    localparam logic [5:0] functOr = 6'h25;
    localparam logic [5:0] functSlt = 6'h2a;

    // Primary opcode, instruction bits 31 to 26.
    typedef enum logic [5:0] {
        opRtype = 6'h00,
        opJ     = 6'h02,
        opBeq   = 6'h04,
        opAddi  = 6'h08,
        opLw    = 6'h23,
        opSw    = 6'h2b
    } opcodeT;

    typedef enum logic [2:0] {
        aluAdd = 3'd0,
        aluSub = 3'd1,
        aluAnd = 3'd2,
        aluOr  = 3'd3,
        aluSlt = 3'd4
    } aluOpT;

    // Operand source picked in execute.
    typedef enum logic [1:0] {
        fwdNone = 2'b00,
        fwdWb   = 2'b01,
        fwdMem  = 2'b10
    } fwdSelT;

    typedef struct packed {
        logic  regWrite;
        logic  memToReg;
        logic  memWrite;
        logic  aluSrc;
        logic  regDst;
        aluOpT aluOp;
    } ctrlT;

    typedef struct packed {
        logic [dataWidth-1:0] pcPlus4;
        logic [dataWidth-1:0] instruction;
    } fetchDecodeT;

    typedef struct packed {
        ctrlT                    ctrl;
        logic [dataWidth-1:0]    rsValue;
        logic [dataWidth-1:0]    rtValue;
        logic [dataWidth-1:0]    imm;
        logic [regAddrWidth-1:0] rs;
        logic [regAddrWidth-1:0] rt;
        logic [regAddrWidth-1:0] rd;
    } decodeExecT;

    typedef struct packed {
        logic                    regWrite;
        logic                    memToReg;
        logic                    memWrite;
        logic [dataWidth-1:0]    aluOut;
        logic [dataWidth-1:0]    writeData;
        logic [regAddrWidth-1:0] writeReg;
    } execMemT;

    typedef struct packed {
        logic                    regWrite;
        logic                    memToReg;
        logic [dataWidth-1:0]    readData;
        logic [dataWidth-1:0]    aluOut;
        logic [regAddrWidth-1:0] writeReg;
    } memWbT;

    typedef struct packed {
        logic                    valid;
        logic [regAddrWidth-1:0] regAddr;
        logic [dataWidth-1:0]    data;
    } wbTraceT;

    typedef struct packed {
        logic [imemAddrWidth-1:0] addr;
        logic [dataWidth-1:0]     word;
    } loadReqT;

endpackage

`default_nettype wire

//--- verilog/fetchStage.sv
`default_nettype none

module fetchStage import cpuPkg::*; (
    input  logic                 clock,
    input  logic                 rstN,
    input  logic                 run,
    input  logic                 stallF,
    input  logic                 flushD,
    input  logic                 branchTaken,
    input  logic [dataWidth-1:0] branchTarget,
    input  loadReqT              loadReq,
    input  logic                 loadStrobe,
    output logic                 loadAck,
    output fetchDecodeT          fetchOut
);

    logic [dataWidth-1:0] pc;
    logic [dataWidth-1:0] pcPlus4;
    logic [dataWidth-1:0] instr;
    logic [dataWidth-1:0] imem [imemDepth];

    assign pcPlus4 = pc + 32'd4;
    assign instr = imem[pc[imemAddrWidth+1:2]];

    // Ack follows the strobe, so it drops only once the source lets go.
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            loadAck <= 1'b0;
        end else begin
            loadAck <= loadStrobe && !run;
        end
    end

    // One write per handshake, in the cycle before ack rises.
    always_ff @(posedge clock) begin
        if (loadStrobe && !loadAck && !run) begin
            imem[loadReq.addr] <= loadReq.word;
        end
    end

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
        end else if (!run) begin
            pc <= '0;
        end else if (branchTaken) begin
            pc <= branchTarget;
        end else if (!stallF) begin
            pc <= pcPlus4;
        end
    end

    // Fetch/decode register.
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            fetchOut <= '0;
        end else if (!run || flushD) begin
            fetchOut <= '0;
        end else if (!stallF) begin
            fetchOut.pcPlus4 <= pcPlus4;
            fetchOut.instruction <= instr;
        end
    end

endmodule

`default_nettype wire

//--- verilog/decodeStage.sv
`default_nettype none

module decodeStage import cpuPkg::*; (
    input  logic                    clock,
    input  logic                    rstN,
    input  logic                    run,
    input  logic                    stallD,
    input  logic                    flushE,
    input  fetchDecodeT             fetchIn,
    input  logic                    wbWrite,
    input  logic [regAddrWidth-1:0] wbReg,
    input  logic [dataWidth-1:0]    wbData,
    input  logic [dataWidth-1:0]    aluOutM,
    input  logic                    fwdBranchA,
    input  logic                    fwdBranchB,
    output decodeExecT              decodeOut,
    output logic                    branchTaken,
    output logic [dataWidth-1:0]    branchTarget,
    output logic [regAddrWidth-1:0] rsD,
    output logic [regAddrWidth-1:0] rtD
);

    logic [dataWidth-1:0]    regs [2**regAddrWidth];
    opcodeT                  opcode;
    logic [5:0]              funct;
    logic [regAddrWidth-1:0] rdD;
    logic [dataWidth-1:0]    immD;
    logic [dataWidth-1:0]    rsValue;
    logic [dataWidth-1:0]    rtValue;
    logic [dataWidth-1:0]    cmpA;
    logic [dataWidth-1:0]    cmpB;
    logic                    isBeq;
    logic                    isJ;
    ctrlT                    ctrl;

    // Register 0 reads as zero; a write in this cycle is seen at once.
    function automatic logic [dataWidth-1:0] readReg(input logic [regAddrWidth-1:0] addr);
        if (addr == '0) begin
            return '0;
        end else if (wbWrite && wbReg == addr) begin
            return wbData;
        end
        return regs[addr];
    endfunction

    assign opcode = opcodeT'(fetchIn.instruction[31:26]);
    assign rsD = fetchIn.instruction[25:21];
    assign rtD = fetchIn.instruction[20:16];
    assign rdD = fetchIn.instruction[15:11];
    assign funct = fetchIn.instruction[5:0];
    assign immD = {{16{fetchIn.instruction[15]}}, fetchIn.instruction[15:0]};
    assign rsValue = readReg(rsD);
    assign rtValue = readReg(rtD);

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            regs <= '{default: '0};
        end else if (wbWrite && wbReg != '0) begin
            regs[wbReg] <= wbData;
        end
    end

    // Unknown opcodes and funct codes decode to a bubble.
    always_comb begin
        ctrl = '0;
        isBeq = 1'b0;
        isJ = 1'b0;
        case (opcode)
            opRtype: begin
                ctrl.regWrite = 1'b1;
                ctrl.regDst = 1'b1;
                case (funct)
                    functAdd: ctrl.aluOp = aluAdd;
                    functSub: ctrl.aluOp = aluSub;
                    functAnd: ctrl.aluOp = aluAnd;
                    functOr:  ctrl.aluOp = aluOr;
                    functSlt: ctrl.aluOp = aluSlt;
                    default:  ctrl = '0;
                endcase
            end
            opAddi: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc = 1'b1;
            end
            opLw: begin
                ctrl.regWrite = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.aluSrc = 1'b1;
            end
            opSw: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc = 1'b1;
            end
            opBeq: isBeq = 1'b1;
            opJ:   isJ = 1'b1;
            default: ctrl = '0;
        endcase
    end

    // Branch compare sees results still sitting in the memory stage.
    assign cmpA = fwdBranchA ? aluOutM : rsValue;
    assign cmpB = fwdBranchB ? aluOutM : rtValue;
    assign branchTaken = !stallD && (isJ || (isBeq && cmpA == cmpB));
    assign branchTarget = isJ ?
        {fetchIn.pcPlus4[31:28], fetchIn.instruction[25:0], 2'b00} :
        fetchIn.pcPlus4 + {immD[dataWidth-3:0], 2'b00};

    // Decode/execute register.
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            decodeOut <= '0;
        end else if (!run || flushE || stallD) begin
            decodeOut <= '0;
        end else begin
            decodeOut.ctrl <= ctrl;
            decodeOut.rsValue <= rsValue;
            decodeOut.rtValue <= rtValue;
            decodeOut.imm <= immD;
            decodeOut.rs <= rsD;
            decodeOut.rt <= rtD;
            decodeOut.rd <= rdD;
        end
    end

endmodule

`default_nettype wire

//--- verilog/executeStage.sv
`default_nettype none

module executeStage import cpuPkg::*; (
    input  logic                 clock,
    input  logic                 rstN,
    input  logic                 run,
    input  decodeExecT           execIn,
    input  fwdSelT               fwdA,
    input  fwdSelT               fwdB,
    input  logic [dataWidth-1:0] aluOutM,
    input  logic [dataWidth-1:0] resultW,
    output execMemT              execOut
);

    logic [dataWidth-1:0]    srcA;
    logic [dataWidth-1:0]    rtFwd;
    logic [dataWidth-1:0]    srcB;
    logic [dataWidth-1:0]    aluResult;
    logic [regAddrWidth-1:0] writeReg;

    function automatic logic [dataWidth-1:0] fwdMux(input fwdSelT sel,
                                                    input logic [dataWidth-1:0] regValue);
        case (sel)
            fwdMem:  return aluOutM;
            fwdWb:   return resultW;
            default: return regValue;
        endcase
    endfunction

    assign srcA = fwdMux(fwdA, execIn.rsValue);
    assign rtFwd = fwdMux(fwdB, execIn.rtValue);
    assign srcB = execIn.ctrl.aluSrc ? execIn.imm : rtFwd;
    assign writeReg = execIn.ctrl.regDst ? execIn.rd : execIn.rt;

    always_comb begin
        case (execIn.ctrl.aluOp)
            aluAdd:  aluResult = srcA + srcB;
            aluSub:  aluResult = srcA - srcB;
            aluAnd:  aluResult = srcA & srcB;
            aluOr:   aluResult = srcA | srcB;
            // Signed compare.
            aluSlt:  aluResult = {{(dataWidth-1){1'b0}}, $signed(srcA) < $signed(srcB)};
            default: aluResult = '0;
        endcase
    end

    // Execute/memory register.
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            execOut <= '0;
        end else if (!run) begin
            execOut <= '0;
        end else begin
            execOut.regWrite <= execIn.ctrl.regWrite;
            execOut.memToReg <= execIn.ctrl.memToReg;
            execOut.memWrite <= execIn.ctrl.memWrite;
            execOut.aluOut <= aluResult;
            execOut.writeData <= rtFwd;
            execOut.writeReg <= writeReg;
        end
    end

endmodule

`default_nettype wire

//--- verilog/memStage.sv
`default_nettype none

module memStage import cpuPkg::*; (
    input  logic    clock,
    input  logic    rstN,
    input  logic    run,
    input  execMemT memIn,
    output memWbT   memOut
);

    logic [dataWidth-1:0]         dmem [dmemDepth];
    logic [$clog2(dmemDepth)-1:0] wordAddr;

    // Word addressed, byte offset dropped.
    assign wordAddr = memIn.aluOut[$clog2(dmemDepth)+1:2];

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            dmem <= '{default: '0};
        end else if (run && memIn.memWrite) begin
            dmem[wordAddr] <= memIn.writeData;
        end
    end

    // Memory/writeback register.
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            memOut <= '0;
        end else if (!run) begin
            memOut <= '0;
        end else begin
            memOut.regWrite <= memIn.regWrite;
            memOut.memToReg <= memIn.memToReg;
            memOut.readData <= dmem[wordAddr];
            memOut.aluOut <= memIn.aluOut;
            memOut.writeReg <= memIn.writeReg;
        end
    end

endmodule

`default_nettype wire

//--- verilog/hazardUnit.sv
`default_nettype none

module hazardUnit import cpuPkg::*; (
    input  logic [regAddrWidth-1:0] rsD,
    input  logic [regAddrWidth-1:0] rtD,
    input  logic                    branchD,
    input  logic                    jumpD,
    input  decodeExecT              execIn,
    input  execMemT                 memIn,
    input  memWbT                   wbIn,
    output fwdSelT                  fwdA,
    output fwdSelT                  fwdB,
    output logic                    fwdBranchA,
    output logic                    fwdBranchB,
    output logic                    stallF,
    output logic                    stallD,
    output logic                    flushE,
    output logic                    flushD
);

    logic [regAddrWidth-1:0] writeRegE;
    logic                    lwStall;
    logic                    branchStall;

    // Youngest producer wins.
    function automatic fwdSelT fwdSelect(input logic [regAddrWidth-1:0] src);
        if (src != '0 && memIn.regWrite && memIn.writeReg == src) begin
            return fwdMem;
        end else if (src != '0 && wbIn.regWrite && wbIn.writeReg == src) begin
            return fwdWb;
        end
        return fwdNone;
    endfunction

    assign writeRegE = execIn.ctrl.regDst ? execIn.rd : execIn.rt;

    assign fwdA = fwdSelect(execIn.rs);
    assign fwdB = fwdSelect(execIn.rt);
    assign fwdBranchA = rsD != '0 && memIn.regWrite && memIn.writeReg == rsD;
    assign fwdBranchB = rtD != '0 && memIn.regWrite && memIn.writeReg == rtD;

    // Load in execute feeding the instruction in decode.
    assign lwStall = execIn.ctrl.memToReg && execIn.rt != '0 &&
                     (execIn.rt == rsD || execIn.rt == rtD);

    // Beq operands not yet available: ALU result in execute, or load data in memory.
    assign branchStall = branchD &&
        ((execIn.ctrl.regWrite && writeRegE != '0 &&
          (writeRegE == rsD || writeRegE == rtD)) ||
         (memIn.memToReg && memIn.writeReg != '0 &&
          (memIn.writeReg == rsD || memIn.writeReg == rtD)));

    assign stallF = lwStall || branchStall;
    assign stallD = lwStall || branchStall;
    assign flushE = lwStall || branchStall;
    // Any redirect from decode squashes the word just fetched.
    assign flushD = jumpD;

endmodule

`default_nettype wire

//--- verilog/cpu.sv
`default_nettype none

module cpu import cpuPkg::*; (
    input  logic    clock,
    input  logic    rstN,
    input  logic    run,
    input  loadReqT loadReq,
    input  logic    loadStrobe,
    output logic    loadAck,
    output wbTraceT trace
);

    fetchDecodeT             fetchDecode;
    decodeExecT              decodeExec;
    execMemT                 execMem;
    memWbT                   memWb;
    logic [dataWidth-1:0]    resultW;
    logic [dataWidth-1:0]    branchTarget;
    logic                    branchTaken;
    logic                    branchD;
    logic [regAddrWidth-1:0] rsD;
    logic [regAddrWidth-1:0] rtD;
    fwdSelT                  fwdA;
    fwdSelT                  fwdB;
    logic                    fwdBranchA;
    logic                    fwdBranchB;
    logic                    stallF;
    logic                    stallD;
    logic                    flushE;
    logic                    flushD;

    assign resultW = memWb.memToReg ? memWb.readData : memWb.aluOut;
    assign branchD = fetchDecode.instruction[31:26] == opBeq;

    // Register 0 writes are dropped, so they are not traced either.
    assign trace.valid = memWb.regWrite && memWb.writeReg != '0;
    assign trace.regAddr = memWb.writeReg;
    assign trace.data = resultW;

    fetchStage u_fetch (
        .clock(clock), .rstN(rstN), .run(run),
        .stallF(stallF), .flushD(flushD),
        .branchTaken(branchTaken), .branchTarget(branchTarget),
        .loadReq(loadReq), .loadStrobe(loadStrobe), .loadAck(loadAck),
        .fetchOut(fetchDecode)
    );

    decodeStage u_decode (
        .clock(clock), .rstN(rstN), .run(run),
        .stallD(stallD), .flushE(flushE), .fetchIn(fetchDecode),
        .wbWrite(memWb.regWrite), .wbReg(memWb.writeReg), .wbData(resultW),
        .aluOutM(execMem.aluOut), .fwdBranchA(fwdBranchA), .fwdBranchB(fwdBranchB),
        .decodeOut(decodeExec), .branchTaken(branchTaken), .branchTarget(branchTarget),
        .rsD(rsD), .rtD(rtD)
    );

    executeStage u_execute (
        .clock(clock), .rstN(rstN), .run(run),
        .execIn(decodeExec), .fwdA(fwdA), .fwdB(fwdB),
        .aluOutM(execMem.aluOut), .resultW(resultW), .execOut(execMem)
    );

    memStage u_mem (
        .clock(clock), .rstN(rstN), .run(run),
        .memIn(execMem), .memOut(memWb)
    );

    // Taken beq and j both redirect fetch, so branchTaken drives the jump input.
    hazardUnit u_hazard (
        .rsD(rsD), .rtD(rtD), .branchD(branchD), .jumpD(branchTaken),
        .execIn(decodeExec), .memIn(execMem), .wbIn(memWb),
        .fwdA(fwdA), .fwdB(fwdB), .fwdBranchA(fwdBranchA), .fwdBranchB(fwdBranchB),
        .stallF(stallF), .stallD(stallD), .flushE(flushE), .flushD(flushD)
    );

endmodule

`default_nettype wire

//--- tests/cpu_asserts.sv
`default_nettype none

module cpuAsserts import cpuPkg::*; (
    input logic        clock,
    input logic        rstN,
    input logic        run,
    input logic        loadStrobe,
    input logic        loadAck,
    input wbTraceT     trace,
    input logic        stallD,
    input fetchDecodeT fetchDecode
);

    timeunit 1ns;
    timeprecision 1ps;

    // Number of failed checks.
    int failCount = 0;

    // Ack only answers a strobe that is still held.
    ackRise: assert property (@(posedge clock) disable iff (!rstN)
        $rose(loadAck) |-> loadStrobe)
        else begin
            failCount++;
            $error("load ack rose without a strobe");
        end

    // Ack stays up until the source has let go.
    ackFall: assert property (@(posedge clock) disable iff (!rstN)
        $fell(loadAck) |-> !loadStrobe)
        else begin
            failCount++;
            $error("load ack fell while the strobe was high");
        end

    ackIdle: assert property (@(posedge clock) disable iff (!rstN)
        run |-> !loadAck)
        else begin
            failCount++;
            $error("load ack is high while the core runs");
        end

    traceHalted: assert property (@(posedge clock) disable iff (!rstN)
        !run |-> !trace.valid)
        else begin
            failCount++;
            $error("trace is valid while the core is halted");
        end

    // Retired data is always known.
    traceData: assert property (@(posedge clock) disable iff (!rstN)
        trace.valid |-> !$isunknown(trace.data))
        else begin
            failCount++;
            $error("trace shows unknown data");
        end

    // A stall keeps the same word in decode for another cycle.
    stallHold: assert property (@(posedge clock) disable iff (!rstN)
        stallD |=> $stable(fetchDecode))
        else begin
            failCount++;
            $error("fetch/decode register changed during a stall");
        end

endmodule

bind cpu cpuAsserts u_asserts (
    .clock(clock), .rstN(rstN), .run(run),
    .loadStrobe(loadStrobe), .loadAck(loadAck), .trace(trace),
    .stallD(stallD), .fetchDecode(fetchDecode)
);

`default_nettype wire

//--- tests/cpuTb.sv
`default_nettype none

module cpuTb import cpuPkg::*;;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int clockPeriod = 100;
    localparam int resetCycles = 3;
    localparam int progLen = 24;
    localparam int drainCycles = 10;
    // Each word takes about five cycles over the handshake.
    localparam int loadCycles = progLen * 6;
    localparam int watchdogCycles = resetCycles + loadCycles + progLen * 10 + drainCycles;

    logic    clock;
    logic    rstN;
    logic    run;
    loadReqT loadReq;
    logic    loadStrobe;
    logic    loadAck;
    wbTraceT trace;

    logic [dataWidth-1:0] progMem [progLen];
    wbTraceT              expQ [$];
    wbTraceT              expected;
    int                   seed;
    int                   traceErrors = 0;
    int                   retired = 0;
    int                   expectedCount = 0;

    cpu u_cpu (
        .clock(clock), .rstN(rstN), .run(run),
        .loadReq(loadReq), .loadStrobe(loadStrobe), .loadAck(loadAck),
        .trace(trace)
    );

    always #(clockPeriod / 2) clock = ~clock;

    function automatic logic [31:0] encodeRtype(input logic [5:0] funct, input logic [4:0] rs,
                                                input logic [4:0] rt, input logic [4:0] rd);
        return {opRtype, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] encodeItype(input opcodeT op, input logic [4:0] rs,
                                                input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] encodeJump(input logic [25:0] index);
        return {opJ, index};
    endfunction

    // ALU chain, register 0, store/load, taken and untaken beq, jump, halt loop.
    task automatic buildProgram();
        logic [15:0] immA;
        logic [15:0] immB;
        logic [15:0] immC;
        immA = 16'($random(seed));
        immB = 16'($random(seed));
        immC = 16'($random(seed));
        if (immB == immA) begin
            immB = immA + 16'd1;
        end
        progMem[0] = encodeItype(opAddi, 5'd0, 5'd1, immA);
        progMem[1] = encodeItype(opAddi, 5'd0, 5'd2, immB);
        progMem[2] = encodeRtype(functAdd, 5'd1, 5'd2, 5'd3);
        progMem[3] = encodeRtype(functSub, 5'd3, 5'd1, 5'd4);
        progMem[4] = encodeRtype(functAnd, 5'd3, 5'd4, 5'd5);
        progMem[5] = encodeRtype(functOr, 5'd5, 5'd2, 5'd6);
        progMem[6] = encodeRtype(functSlt, 5'd1, 5'd2, 5'd7);
        progMem[7] = encodeItype(opAddi, 5'd1, 5'd0, 16'd5);
        progMem[8] = encodeRtype(functAdd, 5'd0, 5'd1, 5'd8);
        progMem[9] = encodeItype(opSw, 5'd0, 5'd3, 16'd8);
        progMem[10] = encodeItype(opLw, 5'd0, 5'd9, 16'd8);
        progMem[11] = encodeRtype(functAdd, 5'd9, 5'd1, 5'd10);
        progMem[12] = encodeItype(opBeq, 5'd10, 5'd10, 16'd1);
        progMem[13] = encodeItype(opAddi, 5'd0, 5'd11, 16'd99);
        progMem[14] = encodeItype(opBeq, 5'd1, 5'd2, 16'd1);
        progMem[15] = encodeItype(opAddi, 5'd0, 5'd12, immC);
        progMem[16] = encodeJump(26'd18);
        progMem[17] = encodeItype(opAddi, 5'd0, 5'd13, 16'd77);
        progMem[18] = encodeItype(opAddi, 5'd12, 5'd14, 16'd1);
        progMem[19] = encodeItype(opLw, 5'd0, 5'd15, 16'd8);
        progMem[20] = encodeItype(opBeq, 5'd15, 5'd3, 16'd1);
        progMem[21] = encodeItype(opAddi, 5'd0, 5'd16, 16'd55);
        progMem[22] = encodeRtype(functAdd, 5'd15, 5'd14, 5'd17);
        progMem[23] = encodeJump(26'd23);
    endtask

    // In-order ISA model; pc counts words and a jump to itself halts.
    task automatic runModel();
        logic [31:0] regs [32];
        logic [31:0] modelMem [dmemDepth];
        logic [31:0] instr;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] addr;
        logic [31:0] result;
        logic [4:0]  dest;
        logic        writes;
        logic        halted;
        wbTraceT     retirement;
        int          pc;
        int          nextPc;
        int          steps;
        foreach (regs[i]) regs[i] = '0;
        foreach (modelMem[i]) modelMem[i] = '0;
        pc = 0;
        steps = 0;
        halted = 1'b0;
        while (!halted && steps < progLen * 4) begin
            instr = progMem[pc];
            a = regs[instr[25:21]];
            b = regs[instr[20:16]];
            imm = {{16{instr[15]}}, instr[15:0]};
            addr = a + imm;
            dest = instr[20:16];
            writes = 1'b0;
            result = '0;
            nextPc = pc + 1;
            case (opcodeT'(instr[31:26]))
                opRtype: begin
                    dest = instr[15:11];
                    writes = 1'b1;
                    case (instr[5:0])
                        functAdd: result = a + b;
                        functSub: result = a - b;
                        functAnd: result = a & b;
                        functOr:  result = a | b;
                        functSlt: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default:  writes = 1'b0;
                    endcase
                end
                opAddi: begin
                    result = addr;
                    writes = 1'b1;
                end
                opLw: begin
                    result = modelMem[addr[7:2]];
                    writes = 1'b1;
                end
                opSw: modelMem[addr[7:2]] = b;
                opBeq: begin
                    if (a == b) begin
                        nextPc = pc + 1 + int'($signed(imm));
                    end
                end
                opJ: nextPc = int'(instr[25:0]);
                default: writes = 1'b0;
            endcase
            if (writes && dest != 5'd0) begin
                regs[dest] = result;
                retirement.valid = 1'b1;
                retirement.regAddr = dest;
                retirement.data = result;
                expQ.push_back(retirement);
            end
            halted = (nextPc == pc);
            pc = nextPc;
            steps++;
        end
    endtask

    // Four-phase write of one instruction word.
    task automatic loadWord(input logic [imemAddrWidth-1:0] addr, input logic [31:0] word);
        @(posedge clock);
        loadReq <= '{addr: addr, word: word};
        loadStrobe <= 1'b1;
        do @(posedge clock); while (!loadAck);
        loadStrobe <= 1'b0;
        do @(posedge clock); while (loadAck);
    endtask

    function automatic int totalErrors();
        return traceErrors + u_cpu.u_asserts.failCount;
    endfunction

    task automatic printReport();
        $display("Retired %0d of %0d, trace errors %0d, assertion errors %0d",
                 retired, expectedCount, traceErrors, u_cpu.u_asserts.failCount);
    endtask

    // Trace is compared against the head of the expected queue.
    always @(posedge clock) begin
        if (rstN && trace.valid) begin
            if (expQ.size() == 0) begin
                traceErrors++;
                $display("MISMATCH %0t ns: unexpected retirement r%0d = %h",
                         $time, trace.regAddr, trace.data);
            end else begin
                expected = expQ.pop_front();
                retired++;
                if (expected.regAddr != trace.regAddr || expected.data != trace.data) begin
                    traceErrors++;
                    $display("MISMATCH %0t ns: got r%0d = %h, expected r%0d = %h", $time,
                             trace.regAddr, trace.data, expected.regAddr, expected.data);
                end
            end
        end
    end

    initial begin
        clock = 1'b0;
        rstN = 1'b0;
        run = 1'b0;
        loadReq = '0;
        loadStrobe = 1'b0;
        seed = 63559;
        buildProgram();
        runModel();
        expectedCount = expQ.size();
        repeat (resetCycles) @(posedge clock);
        rstN <= 1'b1;
        for (int i = 0; i < progLen; i++) begin
            loadWord(imemAddrWidth'(i), progMem[i]);
        end
        @(posedge clock);
        run <= 1'b1;
        while (expQ.size() != 0) @(posedge clock);
        // Window for any extra retirement behind the last one.
        repeat (drainCycles) @(posedge clock);
        printReport();
        if (totalErrors() == 0 && retired == expectedCount) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        #(watchdogCycles * clockPeriod);
        $display("Watchdog expired with %0d retirements still outstanding", expQ.size());
        printReport();
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
verilog/cpuPkg.sv
verilog/fetchStage.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/memStage.sv
verilog/hazardUnit.sv
verilog/cpu.sv
tests/cpu_asserts.sv
tests/cpuTb.sv

//--- Bender.yml
package:
  name: cpu

sources:
  - verilog/cpuPkg.sv
  - verilog/fetchStage.sv
  - verilog/decodeStage.sv
  - verilog/executeStage.sv
  - verilog/memStage.sv
  - verilog/hazardUnit.sv
  - verilog/cpu.sv
  - target: test
    files:
      - tests/cpu_asserts.sv
      - tests/cpuTb.sv
